//--- all.f
pci_pkg.sv
pci_addr_decode.sv
pci_burst_ctrl.sv
pci_target_mem.sv
pci_target.sv
pci_target_assert.sv
tb_bus_check.sv
tb_pci_target.sv

//--- Makefile
TOP = tb_pci_target

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -o sim_exe
	./obj_dir/sim_exe | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb_pci_target.sv
`timescale 1ns/100ps

module tb_pci_target
  import pci_pkg::*;
();

  logic             iframe;
  logic             rst_n;
  logic             frame_n;
  logic             irdy_n;
  logic             cmd;
  logic [BUS_W-1:0] ad_in;
  logic [DEV_W-1:0] device_id;
  logic             trdy_n;
  logic             devsel_n;
  bus_word_u        ad_out;
  logic             ad_oe;

  logic [BUS_W-1:0] wdata [MEM_WORDS];
  integer           seed;
  int               data_errors;
  int               read_checks;
  int               bus_errors;
  int               timeouts;

  always #20 iframe = ~iframe;

  pci_target pci_target_inst (.*);

  tb_bus_check bus_check_inst (.*);

  task automatic fill_data();
    for (int i = 0; i < MEM_WORDS; i++)
    begin
      wdata[i] = $random(seed);
    end
  endtask

  // one control line against its required level
  task automatic expect_level(input string name, input logic actual, input logic expected);
    if (actual !== expected)
    begin
      bus_errors++;
      $display("FAIL at %0t: %s expected %b actual %b", $time, name, expected, actual);
    end
  endtask

  // initiator side of one burst of n words
  task automatic run_burst(input logic rd, input int start, input int n, input bit stalls);
    logic [IDX_W-1:0] slot;
    int               moved;
    int               cycles;
    bit               stall;
    if (timeouts == 0)
    begin
      @(posedge iframe);
      frame_n <= 1'b0;
      cmd     <= rd;
      ad_in   <= {device_id, 6'(start), 2'b00};
      @(posedge iframe);
      slot   = IDX_W'(start);
      moved  = 0;
      cycles = 0;
      while (moved < n && cycles < 40)
      begin
        // frame rises together with irdy on the last word
        stall = stalls && (moved < n - 1) && (($random(seed) & 3) == 0);
        irdy_n  <= stall;
        frame_n <= !stall && (moved == n - 1);
        ad_in   <= wdata[slot];
        @(posedge iframe);
        cycles++;
        if (!irdy_n && !trdy_n)
        begin
          moved++;
          slot = (slot == IDX_W'(MEM_WORDS - 1)) ? '0 : slot + IDX_W'(1);
        end
      end
      frame_n <= 1'b1;
      irdy_n  <= 1'b1;
      if (moved < n)
      begin
        timeouts++;
        $display("timeout waiting for trdy_n in the burst at word %0d", start);
      end
    end
  endtask

  // devsel_n has to stay high for the whole window
  task automatic ignored_burst(input logic [DEV_W-1:0] dev, input int word);
    if (timeouts == 0)
    begin
      @(posedge iframe);
      frame_n <= 1'b0;
      cmd     <= ~cmd_read_c;
      ad_in   <= {dev, 6'(word), 2'b00};
      @(posedge iframe);
      frame_n <= 1'b1;
      irdy_n  <= 1'b0;
      repeat (8)
      begin
        @(posedge iframe);
        expect_level("devsel_n", devsel_n, 1'b1);
      end
      irdy_n <= 1'b1;
    end
  endtask

  initial
  begin
    seed       = 32'h82da7801;
    iframe     = 1'b0;
    rst_n      = 1'b0;
    frame_n    = 1'b1;
    irdy_n     = 1'b1;
    cmd        = 1'b0;
    ad_in      = '0;
    device_id  = 24'h3c5a91;
    bus_errors = 0;
    timeouts   = 0;
    fill_data();
    repeat (8) @(posedge iframe);
    rst_n <= 1'b1;
    @(posedge iframe);
    expect_level("trdy_n", trdy_n, 1'b1);
    expect_level("devsel_n", devsel_n, 1'b1);
    expect_level("ad_oe", ad_oe, 1'b0);
    // cleared memory, then write and read back
    run_burst(cmd_read_c, 0, MEM_WORDS, 1'b0);
    run_burst(~cmd_read_c, 2, 5, 1'b0);
    run_burst(cmd_read_c, 2, 5, 1'b0);
    // foreign device and words past the end
    ignored_burst(device_id ^ 24'h000100, 3);
    ignored_burst(device_id, MEM_WORDS);
    ignored_burst(device_id, 63);
    run_burst(cmd_read_c, 0, MEM_WORDS, 1'b0);
    fill_data();
    run_burst(~cmd_read_c, 1, 7, 1'b1);
    run_burst(cmd_read_c, 1, 7, 1'b1);
    // wrap from word 9 to word 0
    fill_data();
    run_burst(~cmd_read_c, 8, 4, 1'b1);
    run_burst(cmd_read_c, 8, 4, 1'b0);
    run_burst(cmd_read_c, 0, 2, 1'b1);
    repeat (4) @(posedge iframe);
    $display("data errors %0d, bus errors %0d, timeouts %0d, reads checked %0d",
             data_errors, bus_errors, timeouts, read_checks);
    if (data_errors == 0 && bus_errors == 0 && timeouts == 0)
    begin
      $display("Everything OK");
    end
    else
    begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- tb_bus_check.sv
`timescale 1ns/100ps

module tb_bus_check
  import pci_pkg::*;
(
  input  logic             iframe,
  input  logic             rst_n,
  input  logic             frame_n,
  input  logic             irdy_n,
  input  logic             trdy_n,
  input  logic             cmd,
  input  logic [DEV_W-1:0] device_id,
  input  logic [BUS_W-1:0] ad_in,
  input  logic [BUS_W-1:0] ad_out,
  input  logic             ad_oe,
  output int               data_errors,
  output int               read_checks
);

  logic [BUS_W-1:0] shadow [MEM_WORDS];
  logic             frame_q;
  logic             rd_burst;
  logic             ours;
  logic [IDX_W-1:0] pos;

  function automatic logic [BUS_W-1:0] expected_word(input logic [IDX_W-1:0] i);
    return shadow[i];
  endfunction

  always @(posedge iframe)
  begin
    if (!rst_n)
    begin
      shadow      = '{default: '0};
      frame_q     = 1'b1;
      rd_burst    = 1'b0;
      ours        = 1'b0;
      pos         = '0;
      data_errors = 0;
      read_checks = 0;
    end
    else
    begin
      // address phase, index from the low bits of the word field
      if (frame_q && !frame_n)
      begin
        rd_burst = (cmd == cmd_read_c);
        ours     = (ad_in[31:8] == device_id) && (ad_in[7:2] < 6'(MEM_WORDS));
        pos      = ad_in[5:2];
      end
      if (!irdy_n && !trdy_n)
      begin
        if (!ours)
        begin
          // bursts to other devices or past the end get no ready
          data_errors++;
          $display("FAIL at %0t: trdy_n expected 1 actual 0", $time);
        end
        else
        begin
          if (ad_oe !== rd_burst)
          begin
            data_errors++;
            $display("FAIL at %0t: ad_oe expected %b actual %b", $time, rd_burst, ad_oe);
          end
          if (rd_burst)
          begin
            read_checks++;
            if (ad_out !== expected_word(pos))
            begin
              data_errors++;
              $display("FAIL at %0t: ad_out expected %h actual %h", $time,
                       expected_word(pos), ad_out);
            end
          end
          else
          begin
            shadow[pos] = ad_in;
          end
          // wrap at the top word
          pos = (pos == IDX_W'(MEM_WORDS - 1)) ? '0 : pos + IDX_W'(1);
        end
      end
      frame_q = frame_n;
    end
  end

endmodule

//--- pci_target_assert.sv
`timescale 1ns/100ps

module pci_target_assert
(
  input logic iframe,
  input logic rst_n,
  input logic trdy_n,
  input logic devsel_n,
  input logic ad_oe
);

  // only a selected target drives the bus
  oe_selected: assert property (@(posedge iframe) disable iff (!rst_n) ad_oe |-> !devsel_n)
    else $error("ad_oe high while devsel_n is high");

  ready_selected: assert property (@(posedge iframe) disable iff (!rst_n) !trdy_n |-> !devsel_n)
    else $error("trdy_n low while devsel_n is high");

  // first edge out of reset
  reset_idle: assert property (@(posedge iframe) $rose(rst_n) |-> trdy_n && devsel_n)
    else $error("trdy_n or devsel_n active right after reset");

endmodule

bind pci_target pci_target_assert target_assert_inst (.*);

//--- pci_target.sv
`timescale 1ns/100ps

module pci_target
  import pci_pkg::*;
(
  input  logic             iframe,
  input  logic             rst_n,
  input  logic             frame_n,
  input  logic             irdy_n,
  input  logic             cmd,
  input  bus_word_u        ad_in,
  input  logic [DEV_W-1:0] device_id,
  output logic             trdy_n,
  output logic             devsel_n,
  output bus_word_u        ad_out,
  output logic             ad_oe
);

  logic             hit;
  logic             is_read;
  logic [IDX_W-1:0] start_idx;
  logic             busy;

  logic             wr_en;
  logic             rd_load;
  logic [IDX_W-1:0] idx;
  logic             out_en;

  pci_addr_decode addr_decode_inst
  (
    .iframe    (iframe),
    .rst_n     (rst_n),
    .frame_n   (frame_n),
    .cmd       (cmd),
    .ad_in     (ad_in),
    .device_id (device_id),
    .busy      (busy),
    .hit       (hit),
    .is_read   (is_read),
    .start_idx (start_idx)
  );

  pci_burst_ctrl burst_ctrl_inst
  (
    .iframe    (iframe),
    .rst_n     (rst_n),
    .frame_n   (frame_n),
    .irdy_n    (irdy_n),
    .hit       (hit),
    .is_read   (is_read),
    .start_idx (start_idx),
    .busy      (busy),
    .trdy_n    (trdy_n),
    .devsel_n  (devsel_n),
    .wr_en     (wr_en),
    .rd_load   (rd_load),
    .idx       (idx),
    .out_en    (out_en)
  );

  pci_target_mem target_mem_inst
  (
    .iframe  (iframe),
    .rst_n   (rst_n),
    .wr_en   (wr_en),
    .rd_load (rd_load),
    .idx     (idx),
    .out_en  (out_en),
    .ad_in   (ad_in),
    .ad_out  (ad_out),
    .ad_oe   (ad_oe)
  );

endmodule

//--- pci_target_mem.sv
`timescale 1ns/100ps

module pci_target_mem
  import pci_pkg::*;
(
  input  logic             iframe,
  input  logic             rst_n,
  input  logic             wr_en,
  input  logic             rd_load,
  input  logic [IDX_W-1:0] idx,
  input  logic             out_en,
  input  bus_word_u        ad_in,
  output bus_word_u        ad_out,
  output logic             ad_oe
);

  logic [BUS_W-1:0] mem [MEM_WORDS];

  logic read_start;

  // out_en rises during turnaround while the bus is not yet driven
  assign read_start = out_en && !ad_oe;

  always_ff @(posedge iframe)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < MEM_WORDS; i++)
      begin
        mem[i] <= '0;
      end
    end
    else if (wr_en)
    begin
      mem[idx] <= ad_in.data;
    end
  end

  // word shown on the next data phase
  always_ff @(posedge iframe)
  begin
    if (read_start)
    begin
      ad_out.data <= mem[idx];
    end
    else if (rd_load)
    begin
      ad_out.data <= mem[idx_next(idx)];
    end
  end

  always_ff @(posedge iframe)
  begin
    if (!rst_n)
    begin
      ad_oe <= 1'b0;
    end
    else
    begin
      ad_oe <= out_en;
    end
  end

endmodule

//--- pci_burst_ctrl.sv
`timescale 1ns/100ps

module pci_burst_ctrl
  import pci_pkg::*;
(
  input  logic             iframe,
  input  logic             rst_n,
  input  logic             frame_n,
  input  logic             irdy_n,
  input  logic             hit,
  input  logic             is_read,
  input  logic [IDX_W-1:0] start_idx,
  output logic             busy,
  output logic             trdy_n,
  output logic             devsel_n,
  output logic             wr_en,
  output logic             rd_load,
  output logic [IDX_W-1:0] idx,
  output logic             out_en
);

  target_phase_t state;
  target_phase_t state_nx;

  logic read_q;
  logic xfer;
  logic last;

  // trdy_n is only low in the data phase, so irdy_n alone decides a transfer
  assign xfer = (state == data) && !irdy_n;

  // transfer with frame already released ends the burst
  assign last = xfer && frame_n;

  always_comb
  begin
    state_nx = state;
    case (state)
      idle:
      begin
        if (hit)
        begin
          state_nx = is_read ? turn : data;
        end
      end
      turn:
      begin
        state_nx = data;
      end
      data:
      begin
        if (last)
        begin
          state_nx = done;
        end
      end
      done:
      begin
        state_nx = idle;
      end
      default:
      begin
        state_nx = idle;
      end
    endcase
  end

  always_ff @(posedge iframe)
  begin
    if (!rst_n)
    begin
      state    <= idle;
      read_q   <= 1'b0;
      idx      <= '0;
      trdy_n   <= 1'b1;
      devsel_n <= 1'b1;
    end
    else
    begin
      state <= state_nx;

      // select and ready follow the phase we are entering
      devsel_n <= !((state_nx == turn) || (state_nx == data));
      trdy_n   <= !(state_nx == data);

      if ((state == idle) && hit)
      begin
        read_q <= is_read;
        idx    <= start_idx;
      end
      else if (xfer)
      begin
        idx <= idx_next(idx);
      end
    end
  end

  assign busy = (state == turn) || (state == data);

  assign wr_en   = xfer && !read_q;
  assign rd_load = xfer && read_q;

  // drive the bus from turnaround until the last read transfer
  assign out_en = read_q && ((state == turn) || ((state == data) && !last));

endmodule

//--- pci_addr_decode.sv
`timescale 1ns/100ps

module pci_addr_decode
  import pci_pkg::*;
(
  input  logic             iframe,
  input  logic             rst_n,
  input  logic             frame_n,
  input  logic             cmd,
  input  bus_word_u        ad_in,
  input  logic [DEV_W-1:0] device_id,
  input  logic             busy,
  output logic             hit,
  output logic             is_read,
  output logic [IDX_W-1:0] start_idx
);

  logic frame_q;
  logic addr_phase;
  logic dev_match;
  logic word_ok;
  logic take;

  // previous frame level, idle bus is high
  always_ff @(posedge iframe)
  begin
    if (!rst_n)
    begin
      frame_q <= 1'b1;
    end
    else
    begin
      frame_q <= frame_n;
    end
  end

  // first edge with frame low after it was high
  assign addr_phase = frame_q && !frame_n;

  assign dev_match = (ad_in.addr.dev == device_id);
  assign word_ok   = (ad_in.addr.word < WORD_W'(MEM_WORDS));

  // addresses seen during an active burst are not ours to take
  assign take = addr_phase && !busy;

  always_ff @(posedge iframe)
  begin
    if (!rst_n)
    begin
      hit       <= 1'b0;
      is_read   <= 1'b0;
      start_idx <= '0;
    end
    else
    begin
      // single cycle pulse
      hit <= take && dev_match && word_ok;
      if (take)
      begin
        is_read   <= (cmd == cmd_read_c);
        start_idx <= ad_in.addr.word[IDX_W-1:0];
      end
    end
  end

endmodule

//--- pci_pkg.sv
package pci_pkg;

  // bus and memory geometry
  localparam int BUS_W     = 32;
  localparam int MEM_WORDS = 10;
  localparam int IDX_W     = 4;

  // address phase field layout
  localparam int DEV_W  = 24;
  localparam int WORD_W = 6;
  localparam int BYTE_W = 2;

  // command line level for a read, a write is the other level
  localparam logic cmd_read_c = 1'b1;

  // burst controller phases
  typedef enum logic [1:0]
  {
    idle = 2'd0,
    turn = 2'd1,
    data = 2'd2,
    done = 2'd3
  } target_phase_t;

  // one bus word, address view in the address phase, data view otherwise
  typedef union packed
  {
    struct packed
    {
      logic [DEV_W-1:0]  dev;
      logic [WORD_W-1:0] word;
      logic [BYTE_W-1:0] byte_off;
    } addr;
    logic [BUS_W-1:0] data;
  } bus_word_u;

  // word index step with wrap at the top of the memory
  function automatic logic [IDX_W-1:0] idx_next(input logic [IDX_W-1:0] cur);
    logic [IDX_W-1:0] nxt;
    if (cur == IDX_W'(MEM_WORDS - 1))
    begin
      nxt = '0;
    end
    else
    begin
      nxt = cur + IDX_W'(1);
    end
    return nxt;
  endfunction

endpackage
